//--- src/apb_pkg.sv
`include "mem_macros.svh"

package apb_pkg;

  typedef struct packed {
    logic [`ADDR_W-1:0] paddr;    // Doubleword aligned
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`XLEN-1:0]   pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] prdata;
    logic             pready;
  } apb_rsp_t;

  typedef enum logic [2:0] {
    acc_idle,
    acc_rd_setup,
    acc_rd_access,
    acc_wr_setup,
    acc_wr_access,
    acc_drain        // Finish a flushed transfer
  } acc_state_e;

endpackage

//--- src/load_extract.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module load_extract (
  input  mem_stage_pkg::mem_op_e op,
  input  logic [`DW_OFFS_W-1:0]  offset,
  input  logic [`XLEN-1:0]       dword,
  output logic [`XLEN-1:0]       mdata
);
  import mem_stage_pkg::*;

  logic [3:0]            nbytes;
  logic [`DW_OFFS_W-1:0] aligned;
  logic [`XLEN-1:0]      lanes;
  logic                  sign_fill;

  assign nbytes    = op_bytes(op);
  assign aligned   = offset & ~(`DW_OFFS_W'(nbytes - 4'd1));
  assign lanes     = dword >> {aligned, 3'b000};   // Addressed lanes down to bit 0
  assign sign_fill = op_signed(op);

  always_comb begin
    mdata = '0;
    if (op_is_load(op)) begin
      case (nbytes)
        4'd1: begin
          mdata = {{(`XLEN-8){sign_fill & lanes[7]}}, lanes[7:0]};
        end
        4'd2: begin
          mdata = {{(`XLEN-16){sign_fill & lanes[15]}}, lanes[15:0]};
        end
        4'd4: begin
          mdata = {{(`XLEN-32){sign_fill & lanes[31]}}, lanes[31:0]};
        end
        default: begin
          mdata = lanes;                    // ld
        end
      endcase
    end
  end

endmodule

//--- src/mem_access_ctrl.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module mem_access_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  mem_stage_pkg::mem_op_e op,
  input  logic [`XLEN-1:0]       addr,
  input  logic                   req_valid,
  input  logic                   flush,
  input  logic [`XLEN-1:0]       merged_data,
  input  logic [`XLEN-1:0]       store_data,
  output apb_pkg::apb_req_t      apb_req,
  input  apb_pkg::apb_rsp_t      apb_rsp,
  output logic [`XLEN-1:0]       read_dword,
  output logic                   ready
);
  import mem_stage_pkg::*;
  import apb_pkg::*;

  acc_state_e         state;
  acc_state_e         state_next;
  apb_req_t           xfer_q;       // Last driven request that drain replays
  logic [`ADDR_W-1:0] dw_addr;
  logic [`XLEN-1:0]   wr_data;
  logic               is_rmw;

  assign is_rmw  = op_is_store(op) && (op != op_sd);
  assign dw_addr = `ADDR_W'({addr[`XLEN-1:`DW_OFFS_W], {`DW_OFFS_W{1'b0}}});
  assign wr_data = (op == op_sd) ? store_data : merged_data;

  always_comb begin
    state_next = state;
    ready      = 1'b0;
    case (state)
      acc_idle: begin
        ready = flush || (op == op_none);   // Flushed offer is dropped here
        if (req_valid && !flush) begin
          if (op_is_load(op) || is_rmw) begin
            state_next = acc_rd_setup;
          end else if (op == op_sd) begin
            state_next = acc_wr_setup;
          end
        end
      end
      acc_rd_setup: begin
        state_next = flush ? acc_drain : acc_rd_access;
      end
      acc_rd_access: begin
        if (apb_rsp.pready) begin
          ready      = flush || !is_rmw;    // A store still owes its write
          state_next = (is_rmw && !flush) ? acc_wr_setup : acc_idle;
        end else if (flush) begin
          state_next = acc_drain;
        end
      end
      acc_wr_setup: begin
        state_next = flush ? acc_drain : acc_wr_access;
      end
      acc_wr_access: begin
        if (apb_rsp.pready) begin
          ready      = 1'b1;
          state_next = acc_idle;
        end else if (flush) begin
          state_next = acc_drain;
        end
      end
      acc_drain: begin
        if (apb_rsp.pready) begin
          state_next = acc_idle;
        end
      end
      default: begin
        state_next = acc_idle;
      end
    endcase
  end

  always_comb begin
    apb_req        = '0;
    apb_req.paddr  = dw_addr;
    apb_req.pwdata = wr_data;
    case (state)
      acc_rd_setup: begin
        apb_req.psel = 1'b1;
      end
      acc_rd_access: begin
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b1;
      end
      acc_wr_setup: begin
        apb_req.psel   = 1'b1;
        apb_req.pwrite = 1'b1;
      end
      acc_wr_access: begin
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b1;
        apb_req.pwrite  = 1'b1;
      end
      acc_drain: begin
        apb_req         = xfer_q;           // Upstream may already have moved on
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b1;
      end
      default: begin
        apb_req.psel = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= acc_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    xfer_q <= apb_req;
    if (state == acc_rd_access && apb_rsp.pready && is_rmw) begin
      read_dword <= apb_rsp.prdata;        // Old doubleword for the merge
    end
  end

endmodule

//--- src/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Register and data path width
`define XLEN 64

// Data memory address width on the APB port
`define ADDR_W 64

// Destination register number width
`define REGNO_W 5

// Byte offset bits within one doubleword
`define DW_OFFS_W 3

`endif

//--- src/mem_stage.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module mem_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  mem_stage_pkg::mem_req_t    req,
  input  logic                       req_valid,
  output logic                       ready,
  input  logic                       flush,
  output apb_pkg::apb_req_t          apb_req,
  input  apb_pkg::apb_rsp_t          apb_rsp,
  output mem_stage_pkg::mem_result_t result,
  output logic                       result_valid
);

  logic [`XLEN-1:0] merged_data;
  logic [`XLEN-1:0] read_dword;
  logic [`XLEN-1:0] mdata;
  logic             accept;

  assign accept = req_valid && ready && !flush;   // Flushed cycles leave no result

  mem_access_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .op          (req.op),
    .addr        (req.addr),
    .req_valid   (req_valid),
    .flush       (flush),
    .merged_data (merged_data),
    .store_data  (req.rs2),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .read_dword  (read_dword),
    .ready       (ready)
  );

  store_merge u_store_merge (
    .op          (req.op),
    .offset      (req.addr[`DW_OFFS_W-1:0]),
    .rs2         (req.rs2),
    .old_dword   (read_dword),
    .merged_data (merged_data)
  );

  // Load data is taken straight off the bus in the completing cycle
  load_extract u_load_extract (
    .op     (req.op),
    .offset (req.addr[`DW_OFFS_W-1:0]),
    .dword  (apb_rsp.prdata),
    .mdata  (mdata)
  );

  mem_wb_reg u_wb_reg (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .accept       (accept),
    .req          (req),
    .mdata        (mdata),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

//--- src/mem_stage_pkg.sv
`include "mem_macros.svh"

package mem_stage_pkg;

  typedef enum logic [3:0] {
    op_none,      // Not a memory instruction
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_lwu,
    op_ld,
    op_sb,
    op_sh,
    op_sw,
    op_sd
  } mem_op_e;

  typedef struct packed {
    mem_op_e             op;
    logic [`XLEN-1:0]    addr;          // ALU result
    logic [`XLEN-1:0]    rs2;           // Store data
    logic [`REGNO_W-1:0] rd_regno;
    logic                update_rd;
    logic                branch_taken;
    logic [`XLEN-1:0]    pc_target;
  } mem_req_t;

  typedef struct packed {
    mem_op_e             op;
    logic [`XLEN-1:0]    alu_result;
    logic [`XLEN-1:0]    mdata;         // Extended load data or zero
    logic [`REGNO_W-1:0] rd_regno;
    logic                update_rd;
    logic                branch_taken;
    logic [`XLEN-1:0]    pc_target;
  } mem_result_t;

  function automatic logic [3:0] op_bytes(mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 4'd1;
      op_lh, op_lhu, op_sh: return 4'd2;
      op_lw, op_lwu, op_sw: return 4'd4;
      default:              return 4'd8;
    endcase
  endfunction

  function automatic logic op_signed(mem_op_e op);
    return op inside {op_lb, op_lh, op_lw};
  endfunction

  function automatic logic op_is_load(mem_op_e op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  function automatic logic op_is_store(mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

endpackage

//--- src/mem_wb_reg.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module mem_wb_reg (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       accept,
  input  mem_stage_pkg::mem_req_t    req,
  input  logic [`XLEN-1:0]           mdata,
  output mem_stage_pkg::mem_result_t result,
  output logic                       result_valid
);

  // Each accepted operation gives one result in the next cycle
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= accept;
      if (accept) begin
        result.op           <= req.op;
        result.alu_result   <= req.addr;
        result.mdata        <= mdata;
        result.rd_regno     <= req.rd_regno;
        result.update_rd    <= req.update_rd;
        result.branch_taken <= req.branch_taken;
        result.pc_target    <= req.pc_target;
      end
    end
  end

endmodule

//--- src/store_merge.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module store_merge (
  input  mem_stage_pkg::mem_op_e op,
  input  logic [`DW_OFFS_W-1:0]  offset,
  input  logic [`XLEN-1:0]       rs2,
  input  logic [`XLEN-1:0]       old_dword,
  output logic [`XLEN-1:0]       merged_data
);
  import mem_stage_pkg::*;

  logic [3:0]            nbytes;
  logic [`DW_OFFS_W-1:0] aligned;
  logic [`XLEN-1:0]      size_mask;
  logic [`XLEN-1:0]      lane_mask;
  logic [`XLEN-1:0]      rs2_shifted;

  assign nbytes  = op_bytes(op);
  assign aligned = offset & ~(`DW_OFFS_W'(nbytes - 4'd1));   // Low bits ignored

  always_comb begin
    case (nbytes)
      4'd1:    size_mask = {{(`XLEN-8){1'b0}}, 8'hff};
      4'd2:    size_mask = {{(`XLEN-16){1'b0}}, 16'hffff};
      4'd4:    size_mask = {{(`XLEN-32){1'b0}}, 32'hffff_ffff};
      default: size_mask = '1;
    endcase
  end

  assign lane_mask   = size_mask << {aligned, 3'b000};
  assign rs2_shifted = rs2 << {aligned, 3'b000};

  // Selected lanes from rs2 and the rest from memory
  assign merged_data = (old_dword & ~lane_mask) | (rs2_shifted & lane_mask);

endmodule

//--- tb.f
+incdir+src
src/mem_stage_pkg.sv
src/apb_pkg.sv
src/mem_access_ctrl.sv
src/store_merge.sv
src/load_extract.sv
src/mem_wb_reg.sv
src/mem_stage.sv
tests/mem_stage_checker.sv
tests/tb_mem_stage.sv

//--- tests/mem_stage_checker.sv
`timescale 1ns/10ps

module mem_stage_checker (
  input logic              clk,
  input logic              reset,
  input apb_pkg::apb_req_t apb_req,
  input apb_pkg::apb_rsp_t apb_rsp,
  input logic              ready,
  input logic              result_valid
);

  penable_needs_psel: assert property (@(posedge clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel)
    else $error("penable high without psel");

  // Setup phase lasts one cycle
  setup_then_access: assert property (@(posedge clk) disable iff (reset)
    (apb_req.psel && !apb_req.penable) |=> apb_req.penable)
    else $error("APB setup cycle not followed by access");

  req_stable: assert property (@(posedge clk) disable iff (reset)
    (apb_req.psel && !(apb_req.penable && apb_rsp.pready)) |=>
      ($stable(apb_req.paddr) && $stable(apb_req.pwrite) && $stable(apb_req.pwdata)))
    else $error("APB request changed before pready");

  result_pulse: assert property (@(posedge clk) disable iff (reset)
    result_valid |=> !result_valid)
    else $error("result_valid held for two cycles");

  no_early_ready: assert property (@(posedge clk) disable iff (reset)
    (apb_req.psel && !apb_rsp.pready) |-> !ready)
    else $error("ready high during an unfinished APB transfer");

endmodule

bind mem_stage mem_stage_checker u_checker (
  .clk          (clk),
  .reset        (reset),
  .apb_req      (apb_req),
  .apb_rsp      (apb_rsp),
  .ready        (ready),
  .result_valid (result_valid)
);

//--- tests/tb_mem_stage.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module tb_mem_stage;
  import mem_stage_pkg::*;
  import apb_pkg::*;

  localparam int N_RANDOM   = 64;
  localparam int N_OPS      = N_RANDOM + 20;
  localparam int MAX_CYCLES = N_OPS * 20 + 100;
  localparam int MEM_WORDS  = 256;
  localparam int N_WAITS    = 512;

  logic        clk;
  logic        reset;
  mem_req_t    req;
  logic        req_valid;
  logic        ready;
  logic        flush;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  mem_result_t result;
  logic        result_valid;

  logic [`XLEN-1:0]         mem [MEM_WORDS];
  logic [`XLEN-1:0]         shadow [MEM_WORDS];   // Expected memory contents
  int unsigned              wait_tab [N_WAITS];
  int unsigned              wait_idx;
  int unsigned              wait_left;
  int unsigned              xfer_count;           // APB setup cycles seen
  int unsigned              cycles;
  int                       errors;
  int                       checks;
  integer                   seed;
  logic [`ADDR_W-1:0]       exp_paddr;            // Doubleword address of the current op
  mem_result_t              exp_q [$];
  logic [`ADDR_W+`XLEN-1:0] exp_wr_q [$];         // {paddr, pwdata}

  mem_stage u_mem_stage (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .req_valid    (req_valid),
    .ready        (ready),
    .flush        (flush),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .result       (result),
    .result_valid (result_valid)
  );

  always #2 clk = ~clk;

  function automatic logic [`XLEN-1:0] fill_word(int unsigned i);
    return 64'h0123_4567_89ab_cdef ^ {8{i[7:0]}} ^ (64'(i) << 20);
  endfunction

  function automatic int unsigned word_index(logic [`ADDR_W-1:0] a);
    return a[10:3];
  endfunction

  // Predicts the result from the shadow memory and applies stores to it
  function automatic mem_result_t predict_result(mem_req_t r);
    mem_result_t      res;
    int unsigned      nb;
    int unsigned      off;
    int unsigned      idx;
    logic [`XLEN-1:0] old;
    logic [`XLEN-1:0] val;
    res              = '0;
    res.op           = r.op;
    res.alu_result   = r.addr;
    res.rd_regno     = r.rd_regno;
    res.update_rd    = r.update_rd;
    res.branch_taken = r.branch_taken;
    res.pc_target    = r.pc_target;
    nb  = op_bytes(r.op);
    off = r.addr[2:0] & ~(nb - 1);                 // Size-aligned offset
    idx = word_index(r.addr);
    old = shadow[idx];
    val = old;
    if (op_is_load(r.op)) begin
      val = '0;
      for (int i = 0; i < nb; i++) begin
        val[8*i +: 8] = old[8*(off+i) +: 8];
      end
      if (op_signed(r.op) && val[8*nb-1]) begin
        for (int i = nb; i < 8; i++) begin
          val[8*i +: 8] = 8'hff;
        end
      end
      res.mdata = val;
    end else if (op_is_store(r.op)) begin
      for (int i = 0; i < nb; i++) begin
        val[8*(off+i) +: 8] = r.rs2[8*i +: 8];
      end
      shadow[idx] = val;
      exp_wr_q.push_back({r.addr[`ADDR_W-1:3], 3'b000, val});
    end
    return res;
  endfunction

  function automatic mem_req_t make_req(mem_op_e op, logic [`ADDR_W-1:0] addr,
                                        logic [`XLEN-1:0] rs2);
    mem_req_t    r;
    logic [31:0] bits;
    bits           = $random(seed);
    r.op           = op;
    r.addr         = addr;
    r.rs2          = rs2;
    r.rd_regno     = bits[4:0];
    r.update_rd    = bits[5];
    r.branch_taken = bits[6];
    r.pc_target    = {bits, ~bits};
    return r;
  endfunction

  task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic issue(input mem_req_t r);
    int unsigned xfers_before;
    int unsigned xfers_want;
    logic        accepted;
    @(posedge clk);
    #1;
    req       = r;
    req_valid = 1'b1;
    exp_q.push_back(predict_result(r));
    exp_paddr    = {r.addr[`ADDR_W-1:3], 3'b000};
    xfers_before = xfer_count;
    if (r.op == op_none) xfers_want = 0;
    else if (op_is_store(r.op) && r.op != op_sd) xfers_want = 2;   // Read, then write
    else xfers_want = 1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = ready;
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    @(negedge clk);
    checks++;
    assert (result_valid) else begin
      errors++;
      $display("error at %0t: result_valid did not rise one cycle after acceptance", $time);
    end
    check_value("apb transfer count", xfer_count - xfers_before, xfers_want);
  endtask

  // Offer an operation together with flush while the stage is idle
  task automatic flush_offer(input mem_req_t r);
    int unsigned xfers_before;
    @(posedge clk);
    #1;
    req          = r;
    req_valid    = 1'b1;
    flush        = 1'b1;
    xfers_before = xfer_count;
    @(negedge clk);
    checks++;
    assert (ready) else begin
      errors++;
      $display("error at %0t: ready stayed low while flushing an idle stage", $time);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    flush     = 1'b0;
    repeat (4) @(posedge clk);
    check_value("apb transfer count", xfer_count - xfers_before, 0);
  endtask

  // APB slave response driven just after the edge
  always @(posedge clk) begin
    #1;
    if (apb_req.psel && !apb_req.penable) begin
      wait_left      = wait_tab[wait_idx % N_WAITS];
      wait_idx       = wait_idx + 1;
      apb_rsp.pready = 1'b0;
    end else if (apb_req.psel && apb_req.penable) begin
      if (wait_left == 0) begin
        apb_rsp.pready = 1'b1;
        apb_rsp.prdata = mem[word_index(apb_req.paddr)];
      end else begin
        wait_left      = wait_left - 1;
        apb_rsp.pready = 1'b0;
      end
    end else begin
      apb_rsp.pready = 1'b0;
    end
  end

  // APB slave write commit
  always @(posedge clk) begin
    logic [`ADDR_W+`XLEN-1:0] exp_wr;
    if (!reset && apb_req.psel && !apb_req.penable) begin
      xfer_count++;
      check_value("apb_req.paddr", apb_req.paddr, exp_paddr);
    end
    if (!reset && apb_req.psel && apb_req.penable && apb_rsp.pready && apb_req.pwrite) begin
      mem[word_index(apb_req.paddr)] <= apb_req.pwdata;
      checks++;
      assert (exp_wr_q.size() > 0) else begin
        errors++;
        $display("error at %0t: an APB write happened that no store asked for", $time);
      end
      if (exp_wr_q.size() > 0) begin
        exp_wr = exp_wr_q.pop_front();
        check_value("apb_req.paddr", apb_req.paddr, exp_wr[`ADDR_W+`XLEN-1:`XLEN]);
        check_value("apb_req.pwdata", apb_req.pwdata, exp_wr[`XLEN-1:0]);
      end
    end
  end

  // Result comparison
  always @(negedge clk) begin
    mem_result_t exp;
    if (result_valid) begin
      checks++;
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("error at %0t: a result appeared with no operation outstanding", $time);
      end
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        check_value("result.op", 64'(result.op), 64'(exp.op));
        check_value("result.alu_result", result.alu_result, exp.alu_result);
        check_value("result.mdata", result.mdata, exp.mdata);
        check_value("result.rd_regno", 64'(result.rd_regno), 64'(exp.rd_regno));
        check_value("result.update_rd", 64'(result.update_rd), 64'(exp.update_rd));
        check_value("result.branch_taken", 64'(result.branch_taken), 64'(exp.branch_taken));
        check_value("result.pc_target", result.pc_target, exp.pc_target);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("checks %0d, errors %0d", checks, errors);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    seed       = 32'h59fbc024;
    clk        = 1'b0;
    reset      = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    flush      = 1'b0;
    apb_rsp    = '0;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    wait_idx   = 0;
    wait_left  = 0;
    xfer_count = 0;
    exp_paddr  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = fill_word(i);
    end
    for (int i = 0; i < N_WAITS; i++) begin
      wait_tab[i] = {$random(seed)} % 4;
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    issue(make_req(op_none, 64'h1234_5678_9abc_def0, 64'h55));
    issue(make_req(op_sd, 64'h8000_012b, 64'hfedc_ba98_7654_3210));   // Low bits ignored
    issue(make_req(op_ld, 64'h8000_0128, 64'h0));
    issue(make_req(op_sb, 64'h8000_0201, 64'h1111_1111_1111_11a5));
    issue(make_req(op_sh, 64'h8000_0202, 64'h2222_2222_2222_8c3e));
    issue(make_req(op_sw, 64'h8000_0204, 64'h3333_3333_9e0f_4d21));
    issue(make_req(op_ld, 64'h8000_0200, 64'h0));
    for (int k = 0; k < 7; k++) begin
      issue(make_req(mem_op_e'(int'(op_lb) + k), 64'h8000_0055 + 64'(8 * k), 64'h0));
    end
    flush_offer(make_req(op_lw, 64'h8000_0300, 64'h0));
    flush_offer(make_req(op_sb, 64'h8000_0308, 64'hff));
    issue(make_req(op_lw, 64'h8000_0304, 64'h0));
    for (int n = 0; n < N_RANDOM; n++) begin
      issue(make_req(mem_op_e'({$random(seed)} % 12),
                     64'h8000_0000 | 64'({$random(seed)} & 32'h0ff),
                     {$random(seed), $random(seed)}));
    end

    repeat (5) @(posedge clk);
    checks++;
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d expected results never appeared", exp_q.size());
    end
    checks++;
    assert (exp_wr_q.size() == 0) else begin
      errors++;
      $display("%0d expected APB writes never happened", exp_wr_q.size());
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
